// File: logic/isaPkg.sv
package isaPkg;

  localparam int RegCount = 64;                      // Flat file, no register window
  typedef logic [$clog2(RegCount)-1:0] regAddrT;

  localparam regAddrT StackPointerReg = 6'd0;
  localparam regAddrT FlagsReg = 6'd1;

  // Bit positions inside the flags register
  localparam int FlagEqualBit = 0;
  localparam int FlagLessBit = 1;
  localparam int FlagGreaterBit = 2;

  // Kept contiguous from Stall to DoutR, decoder relies on it
  typedef enum logic [7:0] {
    Stall    = 8'h00,
    MovRC    = 8'h01, MovRR    = 8'h02, MovRdC   = 8'h03, MovRdRo  = 8'h04,
    MovdCR   = 8'h05, MovdRoR  = 8'h06,
    PushR    = 8'h07, PopR     = 8'h08, CallR    = 8'h09, Ret      = 8'h0a,
    CmpRR    = 8'h0b, CmpRC    = 8'h0c, CmpLtRRR = 8'h0d,
    JmpC     = 8'h0e, JeC      = 8'h0f, JneC     = 8'h10, JzRC     = 8'h11,
    JnzRC    = 8'h12,
    AddRRR   = 8'h13, AddRRC   = 8'h14, SubRRR   = 8'h15, SubRRC   = 8'h16,
    IncR     = 8'h17, DecR     = 8'h18, ShlRRR   = 8'h19, ShrRRR   = 8'h1a,
    NegRR    = 8'h1b,
    DoutR    = 8'h1c
  } opcodeT;

  typedef struct packed {
    opcodeT  opcode;
    regAddrT regA;                                   // Destination for most ops
    regAddrT regB;
    regAddrT regC;
    logic    eightByte;                              // Data word follows at ip + 4
    logic    memAccess;                              // One data read or write
  } decodedT;

  // Opcodes carrying a constant or address in the following word
  function automatic logic isEightByte(opcodeT op);
    return op inside {MovRC, MovRdC, MovRdRo, MovdCR, MovdRoR, CmpRC, JmpC, JeC, JneC,
                      JzRC, JnzRC, AddRRC, SubRRC};
  endfunction

  // Opcodes that touch data memory, stack ops included
  function automatic logic isMemAccess(opcodeT op);
    return op inside {MovRdC, MovRdRo, MovdCR, MovdRoR, PushR, PopR, CallR, Ret};
  endfunction

endpackage

// File: logic/memBusPkg.sv
package memBusPkg;

  localparam int WordWidth = 32;
  typedef logic [WordWidth-1:0] wordT;

  localparam wordT WordBytes = 32'd4;                // Byte step between words

  // One-cycle strobes, never read and write together
  typedef struct packed {
    logic read;
    logic write;
    wordT address;                                   // Byte address, word aligned
    wordT writeData;
  } memReqT;

  // Value shown by DoutR
  typedef struct packed {
    logic valid;                                     // Single cycle at writeback
    wordT value;
  } debugOutT;

endpackage

// File: logic/instrDecoder.sv
module instrDecoder
  import isaPkg::*, memBusPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  wordT    ramIn,
  input  logic    capture,
  output decodedT decoded
);

  opcodeT fetchedOp;
  logic   stackOp;

  // Anything past the last opcode becomes Stall
  always_comb begin
    if (ramIn[7:0] > 8'(DoutR)) begin
      fetchedOp = Stall;
    end else begin
      fetchedOp = opcodeT'(ramIn[7:0]);
    end
  end

  // Stack ops see the stack pointer through port B
  assign stackOp = fetchedOp inside {PushR, PopR, CallR, Ret};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      decoded <= '0;                                 // Stall, all fields zero
    end else if (capture) begin
      decoded.opcode <= fetchedOp;
      decoded.regA <= ramIn[13:8];                   // Low six bits of each byte
      decoded.regB <= stackOp ? StackPointerReg : ramIn[21:16];
      decoded.regC <= ramIn[29:24];
      decoded.eightByte <= isEightByte(fetchedOp);
      decoded.memAccess <= isMemAccess(fetchedOp);
    end
  end

  // Decoded opcode always a legal one
  assert property (@(posedge clk) disable iff (reset)
    capture |=> (decoded.opcode <= DoutR));

endmodule

// File: logic/regFile.sv
module regFile
  import isaPkg::*, memBusPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  regAddrT addrA,
  input  regAddrT addrB,
  input  regAddrT addrC,
  output wordT    dataA,
  output wordT    dataB,
  output wordT    dataC,
  input  logic    writeEn,
  input  regAddrT writeAddr,
  input  wordT    writeData,
  input  logic    spWriteEn,
  input  wordT    spWriteData,
  output wordT    flags
);

  wordT regs [RegCount];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < RegCount; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (writeEn) begin
        regs[writeAddr] <= writeData;                // Result or flags
      end
      if (spWriteEn) begin
        regs[StackPointerReg] <= spWriteData;        // Push, pop, call, ret
      end
    end
  end

  // Asynchronous reads
  assign dataA = regs[addrA];
  assign dataB = regs[addrB];
  assign dataC = regs[addrC];
  assign flags = regs[FlagsReg];                     // Feeds jump decision directly

  // Pop into r0 would race the stack pointer update
  assert property (@(posedge clk) disable iff (reset)
    !(writeEn && spWriteEn && writeAddr == StackPointerReg));

endmodule

// File: logic/execUnit.sv
module execUnit
  import isaPkg::*, memBusPkg::*;
(
  input  wordT    opA,
  input  wordT    opB,
  input  wordT    opC,
  input  wordT    dataWord,
  input  wordT    loadValue,
  input  wordT    flags,
  input  wordT    ipointer,
  input  decodedT decoded,
  output wordT    result,
  output logic    resultEn,
  output wordT    flagsOut,
  output logic    flagsEn,
  output wordT    spNext,
  output logic    spEn,
  output wordT    ipNext,
  output memReqT  memReq
);

  wordT cmpRhs;
  logic taken;

  assign cmpRhs = (decoded.opcode == CmpRC) ? dataWord : opB;   // Constant or register

  always_comb begin
    result = '0;
    resultEn = 1'b1;                                 // Most ops write register A
    flagsOut = flags;                                // Upper flag bits kept
    flagsEn = 1'b0;
    spNext = opB;                                    // opB is SP for stack ops
    spEn = 1'b0;
    memReq = '0;
    case (decoded.opcode)
      MovRC:    result = dataWord;
      MovRR:    result = opB;
      MovRdC: begin
        memReq.read = 1'b1;
        memReq.address = dataWord;
        result = loadValue;
      end
      MovRdRo: begin
        memReq.read = 1'b1;
        memReq.address = dataWord + opB;             // Base in B, offset in word
        result = loadValue;
      end
      MovdCR: begin
        memReq.write = 1'b1;
        memReq.address = dataWord;
        memReq.writeData = opB;
        resultEn = 1'b0;
      end
      MovdRoR: begin
        memReq.write = 1'b1;
        memReq.address = dataWord + opA;
        memReq.writeData = opB;
        resultEn = 1'b0;
      end
      PushR, CallR: begin
        memReq.write = 1'b1;
        memReq.address = opB;                        // Store at SP, then grow
        memReq.writeData = (decoded.opcode == CallR) ? ipointer : opA;
        spNext = opB + WordBytes;
        spEn = 1'b1;
        resultEn = 1'b0;
      end
      PopR, Ret: begin
        memReq.read = 1'b1;
        memReq.address = opB - WordBytes;            // Top entry sits below SP
        spNext = opB - WordBytes;
        spEn = 1'b1;
        result = loadValue;
        resultEn = (decoded.opcode == PopR);
      end
      CmpRR, CmpRC: begin
        flagsOut[FlagEqualBit] = (opA == cmpRhs);
        flagsOut[FlagLessBit] = (opA < cmpRhs);      // Unsigned
        flagsOut[FlagGreaterBit] = (opA > cmpRhs);
        flagsEn = 1'b1;
        resultEn = 1'b0;
      end
      CmpLtRRR: result = wordT'(opB < opC);
      AddRRR:   result = opB + opC;
      AddRRC:   result = opB + dataWord;
      SubRRR:   result = opB - opC;
      SubRRC:   result = opB - dataWord;
      IncR:     result = opA + 32'd1;
      DecR:     result = opA - 32'd1;
      ShlRRR:   result = opB << opC;
      ShrRRR:   result = opB >> opC;
      NegRR:    result = -opB;
      default:  resultEn = 1'b0;                     // Jumps, stall, debug out
    endcase
  end

  // Branch decision
  always_comb begin
    case (decoded.opcode)
      JmpC:    taken = 1'b1;
      JeC:     taken = flags[FlagEqualBit];
      JneC:    taken = !flags[FlagEqualBit];
      JzRC:    taken = (opA == '0);
      JnzRC:   taken = (opA != '0);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (taken) begin
      ipNext = dataWord;                             // Target in data word
    end else begin
      case (decoded.opcode)
        CallR:   ipNext = opA;
        Ret:     ipNext = loadValue + WordBytes;     // Past the saved call
        Stall:   ipNext = ipointer;
        default: ipNext = ipointer + (decoded.eightByte ? WordBytes << 1 : WordBytes);
      endcase
    end
  end

endmodule

// File: logic/cpuSequencer.sv
module cpuSequencer
  import isaPkg::*, memBusPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  wordT     ramIn,
  input  decodedT  decoded,
  input  memReqT   execReq,
  input  wordT     ipNext,
  input  wordT     regA,
  input  wordT     regB,
  input  wordT     regC,
  output wordT     operandA,
  output wordT     operandB,
  output wordT     operandC,
  output wordT     dataWord,
  output wordT     loadValue,
  output wordT     ipointer,
  output logic     capture,
  output memReqT   memReq,
  output logic     writeback,
  output debugOutT debugOut
);

  typedef enum logic [3:0] {
    Fetch, FetchWait, Decode, RegRead,
    DataWait, DataCapture,
    MemRequest, MemWait, MemCapture,
    Writeback
  } modeT;

  modeT mode;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode <= Fetch;
      ipointer <= '0;
      memReq <= '0;
    end else begin
      memReq.read <= 1'b0;                           // Strobes last one cycle
      memReq.write <= 1'b0;
      case (mode)
        Fetch: begin
          memReq.read <= 1'b1;                       // Instruction word
          memReq.address <= ipointer;
          mode <= FetchWait;
        end
        FetchWait: mode <= Decode;
        Decode:    mode <= RegRead;                  // Decoder captures here
        RegRead: begin
          if (decoded.eightByte) begin
            memReq.read <= 1'b1;                     // Data word behind opcode
            memReq.address <= ipointer + WordBytes;
            mode <= DataWait;
          end else if (decoded.memAccess) begin
            mode <= MemRequest;
          end else begin
            mode <= Writeback;
          end
        end
        DataWait:    mode <= DataCapture;
        DataCapture: mode <= decoded.memAccess ? MemRequest : Writeback;
        MemRequest: begin
          memReq <= execReq;                         // Address and data from execute
          mode <= MemWait;
        end
        MemWait:    mode <= MemCapture;
        MemCapture: mode <= Writeback;
        Writeback: begin
          ipointer <= ipNext;
          mode <= Fetch;
        end
        default: mode <= Fetch;
      endcase
    end
  end

  // Operand and data latches
  always_ff @(posedge clk) begin
    if (mode == RegRead) begin
      operandA <= regA;
      operandB <= regB;
      operandC <= regC;
    end
    if (mode == DataCapture) begin
      dataWord <= ramIn;
    end
    if (mode == MemCapture) begin
      loadValue <= ramIn;                            // Unused for stores
    end
  end

  assign capture = (mode == Decode);
  assign writeback = (mode == Writeback);            // Gates all register writes

  assign debugOut.valid = writeback && (decoded.opcode == DoutR);
  assign debugOut.value = operandA;

  assert property (@(posedge clk) disable iff (reset) !(memReq.read && memReq.write));

  // Stores only ever issued from MemRequest
  assert property (@(posedge clk) disable iff (reset)
    memReq.write |-> $past(mode == MemRequest));

endmodule

// File: logic/cpuCore.sv
module cpuCore
  import isaPkg::*, memBusPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  wordT     ramIn,
  output memReqT   memReq,
  output debugOutT debugOut
);

  decodedT decoded;
  memReqT  execReq;
  wordT    regA, regB, regC, flags;
  wordT    operandA, operandB, operandC;
  wordT    dataWord, loadValue, ipointer, ipNext;
  wordT    result, flagsOut, spNext;
  logic    resultEn, flagsEn, spEn;
  logic    capture, writeback;

  instrDecoder u_instrDecoder (.clk, .reset, .ramIn, .capture, .decoded);

  // Write port carries flags on compares, results otherwise
  regFile u_regFile (
    .clk, .reset,
    .addrA(decoded.regA), .addrB(decoded.regB), .addrC(decoded.regC),
    .dataA(regA), .dataB(regB), .dataC(regC),
    .writeEn(writeback & (resultEn | flagsEn)),
    .writeAddr(flagsEn ? FlagsReg : decoded.regA),
    .writeData(flagsEn ? flagsOut : result),
    .spWriteEn(writeback & spEn),
    .spWriteData(spNext),
    .flags
  );

  execUnit u_execUnit (
    .opA(operandA), .opB(operandB), .opC(operandC),
    .dataWord, .loadValue, .flags, .ipointer, .decoded,
    .result, .resultEn, .flagsOut, .flagsEn, .spNext, .spEn, .ipNext,
    .memReq(execReq)
  );

  cpuSequencer u_cpuSequencer (
    .clk, .reset, .ramIn, .decoded, .execReq, .ipNext,
    .regA, .regB, .regC, .operandA, .operandB, .operandC,
    .dataWord, .loadValue, .ipointer, .capture, .memReq, .writeback, .debugOut
  );

endmodule

// File: bench/testProgram.svh
`ifndef TEST_PROGRAM_SVH
`define TEST_PROGRAM_SVH

// Fixed program, expected debug values pushed in execution order
task automatic loadProgram();
  wordT a;
  wordT b;
  wordT x;
  wordT y;
  wordT z;
  wordT lt;
  a = 32'd7;
  b = 32'd3;
  x = 32'd5;
  y = 32'd5;
  z = 32'd9;
  pc = '0;
  emit(MovRC, 0, 0, 0, StackBase);                  // Stack pointer first
  // Arithmetic on constants
  emit(MovRC, 2, 0, 0, a);
  emit(MovRC, 3, 0, 0, b);
  emit(AddRRR, 4, 2, 3, '0);
  emitDout(4, a + b);
  emit(SubRRC, 4, 2, 0, 32'd5);
  emitDout(4, a - 32'd5);
  emit(IncR, 2, 0, 0, '0);
  a = a + 32'd1;
  emitDout(2, a);
  emit(DecR, 3, 0, 0, '0);
  b = b - 32'd1;
  emitDout(3, b);
  emit(ShlRRR, 5, 2, 3, '0);
  emitDout(5, a << b);
  emit(ShrRRR, 5, 2, 3, '0);
  emitDout(5, a >> b);
  emit(NegRR, 6, 2, 0, '0);
  emitDout(6, -a);
  // Load both LFSR words, add, store
  emit(MovRdC, 7, 0, 0, DataAddr);
  emit(MovRC, 8, 0, 0, DataAddr);
  emit(MovRdRo, 9, 8, 0, WordBytes);                // Base r8 plus offset
  emit(AddRRR, 10, 7, 9, '0);
  emit(MovdCR, 0, 10, 0, StoreAddr);
  emitDout(10, dataWord0 + dataWord1);
  // Compares and jumps
  emit(MovRC, 2, 0, 0, x);
  emit(MovRC, 3, 0, 0, y);
  emit(MovRC, 4, 0, 0, z);
  emit(MovRC, 5, 0, 0, '0);
  emit(CmpRR, 2, 3, 0, '0);
  emitBranch(JeC, 0, x == y, 32'hb1);
  emit(CmpRC, 2, 0, 0, 32'd6);
  emitDout(FlagsReg, {29'd0, x > 32'd6, x < 32'd6, x == 32'd6});   // Greater, less, equal
  emitBranch(JeC, 0, x == 32'd6, 32'hb2);
  emitBranch(JneC, 0, x != 32'd6, 32'hb3);
  emit(CmpLtRRR, 6, 2, 4, '0);
  lt = (x < z) ? 32'd1 : 32'd0;
  emitBranch(JzRC, 6, lt == '0, 32'hb4);
  emitBranch(JnzRC, 6, lt != '0, 32'hb5);
  emitBranch(JzRC, 5, 1'b1, 32'hb6);                // r5 holds zero
  emitBranch(JmpC, 0, 1'b1, 32'hb7);
  // Stack and call
  emit(MovRC, 11, 0, 0, PushValue);
  emit(PushR, 11, 0, 0, '0);
  emit(PopR, 12, 0, 0, '0);
  emitDout(12, PushValue);
  emit(MovRC, 14, 0, 0, 32'hc0);
  emit(MovRC, 13, 0, 0, SubAddr);
  emit(CallR, 13, 0, 0, '0);
  expDout.push_back(32'hc0);                        // Shown inside the subroutine
  emit(MovRC, 20, 0, 0, 32'hc1);
  emitDout(20, 32'hc1);
  emit(Stall, 0, 0, 0, '0);                         // End of program
  pc = SubAddr;
  emit(DoutR, 14, 0, 0, '0);
  emit(Ret, 0, 0, 0, '0);
endtask

`endif

// File: bench/cpuCoreTb.sv
module cpuCoreTb
  import isaPkg::*, memBusPkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MemWords = 1024;
  localparam wordT StackBase = 32'h400;
  localparam wordT SubAddr = 32'h300;
  localparam wordT BadTarget = 32'h3f0;             // Target of untaken jumps
  localparam wordT DataAddr = 32'h800;
  localparam wordT StoreAddr = 32'h900;
  localparam wordT PushValue = 32'h1234;

  // Expected data access of a stack op
  typedef struct packed {
    logic write;
    wordT address;
    wordT data;
  } accessT;

  logic     clk = 1'b0;
  logic     reset;
  wordT     ramIn;
  memReqT   memReq;
  debugOutT debugOut;

  wordT   mem [MemWords];
  logic   skipped [MemWords];                       // Never to be fetched
  wordT   expDout [$];
  wordT   pc;
  int     instrCount = 0;
  wordT   dataWord0;
  wordT   dataWord1;
  logic [31:0] lfsrState = 32'he50e;
  int     pendingAccesses = 0;                      // Non-fetch strobes still due
  opcodeT lastOp = Stall;
  wordT   prevFetch = 32'hffff_ffff;
  wordT   callReturn = '0;
  wordT   spModel = StackBase;
  accessT expStack;
  logic   storeSeen = 1'b0;
  logic   done = 1'b0;

  cpuCore u_cpuCore (.clk, .reset, .ramIn, .memReq, .debugOut);

  always #20 clk = ~clk;

  task automatic reportMismatch(string test, wordT expected, wordT actual);
    $display("Fail %s expected %h actual %h", test, expected, actual);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic reportError(string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic randomWord(output wordT w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsrState = lfsrNext(lfsrState);
      w = {w[30:0], lfsrState[0]};                  // One step per bit
    end
  endtask

  function automatic wordT encode(opcodeT op, regAddrT ra, regAddrT rb, regAddrT rc);
    return {2'b00, rc, 2'b00, rb, 2'b00, ra, 8'(op)};
  endfunction

  function automatic opcodeT opcodeOf(wordT w);
    if (w[7:0] > 8'(DoutR)) begin
      return Stall;                                 // Same as decoder rule
    end
    return opcodeT'(w[7:0]);
  endfunction

  task automatic emit(opcodeT op, regAddrT ra, regAddrT rb, regAddrT rc, wordT data);
    mem[pc[11:2]] = encode(op, ra, rb, rc);
    if (isEightByte(op)) begin
      mem[pc[11:2] + 10'd1] = data;                 // Data word behind opcode
      pc = pc + 32'd8;
    end else begin
      pc = pc + 32'd4;
    end
    instrCount++;
  endtask

  task automatic emitDout(regAddrT ra, wordT expected);
    emit(DoutR, ra, 0, 0, '0);
    expDout.push_back(expected);
  endtask

  // Jump, skipped bad marker when taken, then the real marker
  task automatic emitBranch(opcodeT op, regAddrT ra, logic taken, wordT marker);
    emit(op, ra, 0, 0, taken ? pc + 32'd20 : BadTarget);
    if (taken) begin
      skipped[pc[11:2]] = 1'b1;
      skipped[pc[11:2] + 10'd1] = 1'b1;
      skipped[pc[11:2] + 10'd2] = 1'b1;
      emit(MovRC, 20, 0, 0, 32'hbad);
      emit(DoutR, 20, 0, 0, '0);
    end
    emit(MovRC, 20, 0, 0, marker);
    emitDout(20, marker);
  endtask

  `include "testProgram.svh"

  // Memory model and bus checks, strobes sampled mid-cycle
  always @(negedge clk) begin
    if (reset) begin
      assert (!memReq.read && !memReq.write && !debugOut.valid)
        else reportError("Strobe or debug valid high during reset");
    end else if (memReq.read || memReq.write) begin
      if (memReq.read) begin
        ramIn <= mem[memReq.address[11:2]];
      end
      if (pendingAccesses == 0) begin             // Instruction fetch
        assert (memReq.read) else reportError("Write strobe where a fetch was due");
        assert (!skipped[memReq.address[11:2]])
          else reportError($sformatf("Fetch from skipped address %h", memReq.address));
        if (lastOp == Ret) begin
          assert (memReq.address == callReturn)
            else reportMismatch("retTarget", callReturn, memReq.address);
        end
        if (memReq.address == prevFetch) begin
          done = 1'b1;                              // Final stall reached
        end
        prevFetch = memReq.address;
        lastOp = opcodeOf(mem[memReq.address[11:2]]);
        pendingAccesses = int'(isEightByte(lastOp)) + int'(isMemAccess(lastOp));
        case (lastOp)
          PushR, CallR: begin
            expStack = '{1'b1, spModel, (lastOp == CallR) ? memReq.address : PushValue};
            spModel = spModel + WordBytes;
            callReturn = memReq.address + WordBytes;
          end
          PopR, Ret: begin
            expStack = '{1'b0, spModel - WordBytes, '0};
            spModel = spModel - WordBytes;
          end
          default: ;
        endcase
      end else begin
        pendingAccesses--;
        if (pendingAccesses == 0 && lastOp inside {PushR, PopR, CallR, Ret}) begin
          assert (memReq.write == expStack.write)
            else reportError("Stack access in wrong direction");
          assert (memReq.address == expStack.address)
            else reportMismatch("stackAddress", expStack.address, memReq.address);
          if (expStack.write) begin
            assert (memReq.writeData == expStack.data)
              else reportMismatch("stackData", expStack.data, memReq.writeData);
          end
        end
        if (memReq.write && lastOp == MovdCR) begin
          assert (memReq.address == StoreAddr)
            else reportMismatch("storeAddress", StoreAddr, memReq.address);
          assert (memReq.writeData == dataWord0 + dataWord1)
            else reportMismatch("storeData", dataWord0 + dataWord1, memReq.writeData);
          storeSeen = 1'b1;
        end
      end
      if (memReq.write) begin
        mem[memReq.address[11:2]] = memReq.writeData;
      end
    end
    if (!reset && debugOut.valid) begin
      assert (expDout.size() > 0) else reportError("Unexpected debug output");
      assert (debugOut.value == expDout[0])
        else reportMismatch("debugOut", expDout[0], debugOut.value);
      void'(expDout.pop_front());
    end
  end

  initial begin
    reset = 1'b1;
    ramIn = '0;
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = {24'(i), 8'hff};                     // Unknown opcode, decodes as stall
      skipped[i] = 1'b0;
    end
    randomWord(dataWord0);
    randomWord(dataWord1);
    mem[DataAddr[11:2]] = dataWord0;
    mem[DataAddr[11:2] + 10'd1] = dataWord1;
    skipped[BadTarget[11:2]] = 1'b1;
    loadProgram();
    repeat (2) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    assert (memReq.read && !memReq.write)
      else reportError("No read strobe on the first clock after reset");
    assert (memReq.address == '0)
      else reportMismatch("firstFetch", '0, memReq.address);
    wait (done);
    @(negedge clk);
    if (expDout.size() == 0 && storeSeen) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("Program ended with %0d debug values missing or no store", expDout.size());
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  end

  // Watchdog, ten cycles per instruction plus margin
  initial begin
    #1;
    #((instrCount + 8) * 10 * 40 + 4000);
    $display("Timeout before the program reached its final stall");
    $display("TEST RESULT: FAIL");
    $fatal(1);
  end

endmodule

// File: cpuCore.f
+incdir+bench
logic/isaPkg.sv
logic/memBusPkg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/execUnit.sv
logic/cpuSequencer.sv
logic/cpuCore.sv
bench/cpuCoreTb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then decide pass or fail from the simulation log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f cpuCore.f --top-module cpuCoreTb \
  -o simCpuCore > build.log 2>&1 \
  && { ./obj_dir/simCpuCore > sim.log 2>&1 || true; } \
  && grep -q "TEST RESULT: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
